// ==== lsu_mpu.f ====
lsu_mpu_pkg.sv
lsu_mpu_pma.sv
lsu_mpu_pmp.sv
lsu_mpu_outstanding.sv
lsu_mpu.sv
lsu_mpu_top.sv
tb_lsu_mpu.sv

// ==== lsu_mpu.sv ====
// Data-side memory protection unit
// Checks each core request against PMA and PMP, forwards passing ones to the
// bus with attributes, and absorbs failing ones with an ordered error response
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu #(
  parameter int                    PMA_NUM_REGIONS = 3,
  parameter lsu_mpu_pkg::pma_cfg_t PMA_CFG [PMA_NUM_REGIONS-1:0] =
    '{default: lsu_mpu_pkg::PMA_R_DEFAULT},
  parameter int                    PMP_NUM_REGIONS = 4,
  parameter lsu_mpu_pkg::addr_t    DM_REGION_START = 32'hF000_0000,
  parameter lsu_mpu_pkg::addr_t    DM_REGION_END   = 32'hF000_3FFF
) (
  input  logic                    clk,
  input  logic                    rst_n,

  input  logic                    misaligned_i,

  // Core side
  input  logic                    core_trans_valid_i,
  input  lsu_mpu_pkg::data_req_t  core_trans_i,
  output logic                    core_trans_ready_o,
  output logic                    core_resp_valid_o,
  output lsu_mpu_pkg::core_resp_t core_resp_o,

  // Bus side
  output logic                    bus_trans_valid_o,
  output lsu_mpu_pkg::data_req_t  bus_trans_o,
  input  logic                    bus_trans_ready_i,
  input  logic                    bus_resp_valid_i,
  input  lsu_mpu_pkg::bus_resp_t  bus_resp_i,

  input  lsu_mpu_pkg::pmp_csr_t   csr_pmp_i,
  // Exactly one transaction pending next cycle
  input  logic                    one_txn_pend_next_i,
  output logic                    mpu_err_o
);

  lsu_mpu_pkg::mpu_state_e  state_q, state_n;
  lsu_mpu_pkg::mpu_status_e mpu_status;
  logic pma_err;
  logic pmp_err;
  logic mpu_err;
  logic block_core;
  logic block_bus;
  logic err_resp_valid;
  logic err_trans_ready;
  logic pma_bufferable;
  logic pma_cacheable;
  logic debug_region;

  // Debug mode access into the debug module range
  assign debug_region = core_trans_i.dbg &&
                        (core_trans_i.addr >= DM_REGION_START) &&
                        (core_trans_i.addr <= DM_REGION_END);

  lsu_mpu_pma #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG)
  ) u_pma (
    .addr_i         (core_trans_i.addr),
    .debug_region_i (debug_region),
    .misaligned_i   (misaligned_i),
    .pma_err_o      (pma_err),
    .bufferable_o   (pma_bufferable),
    .cacheable_o    (pma_cacheable)
  );

  lsu_mpu_pmp #(
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS)
  ) u_pmp (
    .csr_pmp_i      (csr_pmp_i),
    .priv_i         (core_trans_i.priv),
    .addr_i         (core_trans_i.addr),
    .we_i           (core_trans_i.we),
    .debug_region_i (debug_region),
    .pmp_err_o      (pmp_err)
  );

  assign mpu_err   = pma_err || pmp_err;
  assign mpu_err_o = mpu_err;

  //////////////////////////////////////////////////////////////////////////
  // Error FSM
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_n         = state_q;
    mpu_status      = lsu_mpu_pkg::MPU_OK;
    block_core      = 1'b0;
    block_bus       = 1'b0;
    err_resp_valid  = 1'b0;
    err_trans_ready = 1'b0;

    case (state_q)
      lsu_mpu_pkg::MPU_IDLE: begin
        if (core_trans_valid_i && mpu_err) begin
          // Keep it off the bus and accept it here
          block_bus       = 1'b1;
          err_trans_ready = 1'b1;
          if (core_trans_i.we) begin
            state_n = one_txn_pend_next_i ? lsu_mpu_pkg::MPU_WR_ERR_RESP
                                          : lsu_mpu_pkg::MPU_WR_ERR_WAIT;
          end else begin
            state_n = one_txn_pend_next_i ? lsu_mpu_pkg::MPU_RE_ERR_RESP
                                          : lsu_mpu_pkg::MPU_RE_ERR_WAIT;
          end
        end
      end
      lsu_mpu_pkg::MPU_RE_ERR_WAIT, lsu_mpu_pkg::MPU_WR_ERR_WAIT: begin
        // Drain earlier bus traffic, only the absorbed request left after that
        block_core = 1'b1;
        block_bus  = 1'b1;
        if (one_txn_pend_next_i) begin
          state_n = (state_q == lsu_mpu_pkg::MPU_RE_ERR_WAIT) ? lsu_mpu_pkg::MPU_RE_ERR_RESP
                                                             : lsu_mpu_pkg::MPU_WR_ERR_RESP;
        end
      end
      lsu_mpu_pkg::MPU_RE_ERR_RESP, lsu_mpu_pkg::MPU_WR_ERR_RESP: begin
        block_core     = 1'b1;
        block_bus      = 1'b1;
        err_resp_valid = 1'b1;
        mpu_status     = (state_q == lsu_mpu_pkg::MPU_RE_ERR_RESP) ? lsu_mpu_pkg::MPU_RE_FAULT
                                                                  : lsu_mpu_pkg::MPU_WR_FAULT;
        // Core always takes the response
        state_n        = lsu_mpu_pkg::MPU_IDLE;
      end
      default: begin
        state_n = lsu_mpu_pkg::MPU_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= lsu_mpu_pkg::MPU_IDLE;
    end else begin
      state_q <= state_n;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Request and response paths
  //////////////////////////////////////////////////////////////////////////

  assign bus_trans_valid_o  = core_trans_valid_i && !block_bus;
  assign core_trans_ready_o = (bus_trans_ready_i && !block_core) || err_trans_ready;

  // Memtype comes from the PMA, not from the core
  always_comb begin
    bus_trans_o         = core_trans_i;
    bus_trans_o.memtype = {pma_cacheable, pma_bufferable};
  end

  assign core_resp_valid_o = bus_resp_valid_i || err_resp_valid;

  always_comb begin
    core_resp_o.mpu_status = mpu_status;
    // Error responses carry no bus data
    core_resp_o.bus_resp   = err_resp_valid ? '0 : bus_resp_i;
  end

  // No bus request while a fault is being handled
  a_no_bus_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(bus_trans_valid_o) |-> (state_q == lsu_mpu_pkg::MPU_IDLE)
  ) else $error("lsu_mpu: bus valid rose outside idle");

  // Tracker must have seen the last bus response before the fault reply
  a_resp_no_overlap: assert property (
    @(posedge clk) disable iff (!rst_n)
    err_resp_valid |-> !bus_resp_valid_i
  ) else $error("lsu_mpu: bus response collided with fault response");

endmodule

`default_nettype wire

// ==== lsu_mpu_outstanding.sv ====
// Outstanding transaction tracker
// Counts accepted but unanswered core transactions
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu_outstanding (
  input  logic clk,
  input  logic rst_n,
  input  logic accept_i,
  input  logic resp_i,
  output logic one_txn_pend_next_o
);

  logic [2:0] cnt_q;
  logic [2:0] cnt_n;

  // Accept and response together cancel out
  always_comb begin
    cnt_n = cnt_q;
    if (accept_i && !resp_i) begin
      cnt_n = cnt_q + 3'd1;
    end else if (resp_i && !accept_i) begin
      cnt_n = cnt_q - 3'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_n;
    end
  end

  assign one_txn_pend_next_o = (cnt_n == 3'd1);

  // Response without any transaction in flight
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (resp_i && !accept_i) |-> (cnt_q != 3'd0)
  ) else $error("lsu_mpu_outstanding: count underflow");

  // More in flight than the counter can hold
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    (accept_i && !resp_i) |-> (cnt_q != 3'd7)
  ) else $error("lsu_mpu_outstanding: count overflow");

endmodule

`default_nettype wire

// ==== lsu_mpu_pkg.sv ====
// LSU memory protection unit package
// Shared widths, enums and packed structs for the PMA and PMP checks,
// the core and bus request paths and the PMP CSR image
`default_nettype none

package lsu_mpu_pkg;

  // Byte address and data word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;

  // Upper bound on PMP regions held in the CSR image
  localparam int PMP_MAX_REGIONS = 4;

  // Privilege levels, encoded as in the RISC-V spec
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_M = 2'b11
  } privlvl_e;

  // Status returned with every core response
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  // Protection unit FSM states
  typedef enum logic [2:0] {
    MPU_IDLE,
    MPU_RE_ERR_WAIT,
    MPU_WR_ERR_WAIT,
    MPU_RE_ERR_RESP,
    MPU_WR_ERR_RESP
  } mpu_state_e;

  // Request from core, also sent to bus
  // memtype bit 0 bufferable, bit 1 cacheable
  typedef struct packed {
    addr_t      addr;
    logic       we;
    logic [3:0] be;
    data_t      wdata;
    privlvl_e   priv;
    logic       dbg;
    logic [1:0] memtype;
  } data_req_t;

  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_resp_t;

  typedef struct packed {
    bus_resp_t   bus_resp;
    mpu_status_e mpu_status;
  } core_resp_t;

  // One top-of-range PMP region
  typedef struct packed {
    addr_t top;
    logic  r;
    logic  w;
    logic  en;
    logic  lock;
  } pmp_region_t;

  typedef pmp_region_t [PMP_MAX_REGIONS-1:0] pmp_csr_t;

  // Fixed PMA region, base and last are inclusive
  typedef struct packed {
    addr_t base;
    addr_t last;
    logic  main;
    logic  bufferable;
    logic  cacheable;
  } pma_cfg_t;

  // Whole address space, main memory, no buffering or caching
  localparam pma_cfg_t PMA_R_DEFAULT = '{
    base       : 32'h0000_0000,
    last       : 32'hFFFF_FFFF,
    main       : 1'b1,
    bufferable : 1'b0,
    cacheable  : 1'b0
  };

endpackage

`default_nettype wire

// ==== lsu_mpu_pma.sv ====
// Physical memory attribute lookup
// Scans a fixed region table and returns legality and bus attributes
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu_pma #(
  parameter int                    PMA_NUM_REGIONS = 3,
  parameter lsu_mpu_pkg::pma_cfg_t PMA_CFG [PMA_NUM_REGIONS-1:0] =
    '{default: lsu_mpu_pkg::PMA_R_DEFAULT}
) (
  input  lsu_mpu_pkg::addr_t addr_i,
  input  logic               debug_region_i,
  input  logic               misaligned_i,
  output logic               pma_err_o,
  output logic               bufferable_o,
  output logic               cacheable_o
);

  // Attributes of the selected region
  lsu_mpu_pkg::pma_cfg_t pma_cfg;
  logic                  region_hit;

  //////////////////////////////////////////////////////////////////////////
  // Region select
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    pma_cfg    = lsu_mpu_pkg::PMA_R_DEFAULT;
    region_hit = 1'b0;
    // First hit in table order wins
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      if (!region_hit && (addr_i >= PMA_CFG[i].base) && (addr_i <= PMA_CFG[i].last)) begin
        pma_cfg    = PMA_CFG[i];
        region_hit = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Error and attributes
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (debug_region_i) begin
      // Debug module access, always legal and never buffered or cached
      pma_err_o    = 1'b0;
      bufferable_o = 1'b0;
      cacheable_o  = 1'b0;
    end else begin
      // Split accesses only allowed to main memory
      pma_err_o    = misaligned_i && !pma_cfg.main;
      bufferable_o = pma_cfg.bufferable;
      cacheable_o  = pma_cfg.cacheable;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_mpu_pmp.sv ====
// Physical memory protection check, top-of-range regions only
// Applies region permissions by privilege level and lock bit
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu_pmp #(
  parameter int PMP_NUM_REGIONS = 4
) (
  input  lsu_mpu_pkg::pmp_csr_t csr_pmp_i,
  input  lsu_mpu_pkg::privlvl_e priv_i,
  input  lsu_mpu_pkg::addr_t    addr_i,
  input  logic                  we_i,
  input  logic                  debug_region_i,
  output logic                  pmp_err_o
);

  // Lowest matching enabled region
  lsu_mpu_pkg::pmp_region_t match_region;
  logic                     match_found;
  // Running lower bound, the previous region's top
  lsu_mpu_pkg::addr_t       range_lo;
  // Permission needed by this access is granted by the match
  logic                     perm_ok;

  //////////////////////////////////////////////////////////////////////////
  // Region match
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    match_region = '0;
    match_found  = 1'b0;
    range_lo     = '0;
    for (int i = 0; i < PMP_NUM_REGIONS; i++) begin
      if (!match_found && csr_pmp_i[i].en &&
          (addr_i >= range_lo) && (addr_i < csr_pmp_i[i].top)) begin
        match_region = csr_pmp_i[i];
        match_found  = 1'b1;
      end
      // Disabled regions still set the bound for the next one
      range_lo = csr_pmp_i[i].top;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // Permission decision
  //////////////////////////////////////////////////////////////////////////

  always_comb begin
    perm_ok = we_i ? match_region.w : match_region.r;

    if (debug_region_i) begin
      pmp_err_o = 1'b0;
    end else if (priv_i == lsu_mpu_pkg::PRIV_M) begin
      // Machine mode only bound by locked regions
      pmp_err_o = match_found && match_region.lock && !perm_ok;
    end else begin
      // User mode needs a matching region that grants access
      pmp_err_o = !match_found || !perm_ok;
    end
  end

endmodule

`default_nettype wire

// ==== lsu_mpu_top.sv ====
// LSU protection subsystem top
// Protection unit plus its outstanding transaction tracker
`timescale 1ns/100ps
`default_nettype none

module lsu_mpu_top #(
  parameter int                    PMA_NUM_REGIONS = 3,
  parameter lsu_mpu_pkg::pma_cfg_t PMA_CFG [PMA_NUM_REGIONS-1:0] =
    '{default: lsu_mpu_pkg::PMA_R_DEFAULT},
  parameter int                    PMP_NUM_REGIONS = 4,
  parameter lsu_mpu_pkg::addr_t    DM_REGION_START = 32'hF000_0000,
  parameter lsu_mpu_pkg::addr_t    DM_REGION_END   = 32'hF000_3FFF
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    misaligned_i,
  input  logic                    core_trans_valid_i,
  input  lsu_mpu_pkg::data_req_t  core_trans_i,
  output logic                    core_trans_ready_o,
  output logic                    core_resp_valid_o,
  output lsu_mpu_pkg::core_resp_t core_resp_o,
  output logic                    bus_trans_valid_o,
  output lsu_mpu_pkg::data_req_t  bus_trans_o,
  input  logic                    bus_trans_ready_i,
  input  logic                    bus_resp_valid_i,
  input  lsu_mpu_pkg::bus_resp_t  bus_resp_i,
  input  lsu_mpu_pkg::pmp_csr_t   csr_pmp_i,
  output logic                    mpu_err_o
);

  // Tracker to FSM
  logic one_txn_pend_next;

  lsu_mpu #(
    .PMA_NUM_REGIONS (PMA_NUM_REGIONS),
    .PMA_CFG         (PMA_CFG),
    .PMP_NUM_REGIONS (PMP_NUM_REGIONS),
    .DM_REGION_START (DM_REGION_START),
    .DM_REGION_END   (DM_REGION_END)
  ) u_mpu (
    .clk                 (clk),
    .rst_n               (rst_n),
    .misaligned_i        (misaligned_i),
    .core_trans_valid_i  (core_trans_valid_i),
    .core_trans_i        (core_trans_i),
    .core_trans_ready_o  (core_trans_ready_o),
    .core_resp_valid_o   (core_resp_valid_o),
    .core_resp_o         (core_resp_o),
    .bus_trans_valid_o   (bus_trans_valid_o),
    .bus_trans_o         (bus_trans_o),
    .bus_trans_ready_i   (bus_trans_ready_i),
    .bus_resp_valid_i    (bus_resp_valid_i),
    .bus_resp_i          (bus_resp_i),
    .csr_pmp_i           (csr_pmp_i),
    .one_txn_pend_next_i (one_txn_pend_next),
    .mpu_err_o           (mpu_err_o)
  );

  // Counts core-side handshakes, faulting requests included
  lsu_mpu_outstanding u_outstanding (
    .clk                 (clk),
    .rst_n               (rst_n),
    .accept_i            (core_trans_valid_i && core_trans_ready_o),
    .resp_i              (core_resp_valid_o),
    .one_txn_pend_next_o (one_txn_pend_next)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the LSU MPU testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_lsu_mpu \
  -f lsu_mpu.f \
  --Mdir obj_dir \
  -o tb_lsu_mpu

./obj_dir/tb_lsu_mpu | tee sim.log

if grep -qx "=== PASS ===" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

// ==== tb_lsu_mpu.sv ====
// Testbench for the LSU protection subsystem
// Random-ready bus responder, reference model of the PMA and PMP rules and an
// in-order checker for every core response
`timescale 1ns/100ps
`default_nettype none

module tb_lsu_mpu;

  localparam int                 TIMEOUT_CYCLES = 200;
  localparam lsu_mpu_pkg::addr_t DM_START       = 32'hF000_0000;
  localparam lsu_mpu_pkg::addr_t DM_END         = 32'hF000_3FFF;

  // PMA table, RAM then I/O then debug module
  localparam lsu_mpu_pkg::pma_cfg_t RAM_CFG = '{base: 32'h0000_0000, last: 32'h0000_FFFF,
                                                main: 1'b1, bufferable: 1'b1, cacheable: 1'b1};
  localparam lsu_mpu_pkg::pma_cfg_t IO_CFG  = '{base: 32'h1000_0000, last: 32'h1000_0FFF,
                                                main: 1'b0, bufferable: 1'b0, cacheable: 1'b0};
  localparam lsu_mpu_pkg::pma_cfg_t DM_CFG  = '{base: DM_START, last: DM_END,
                                                main: 1'b0, bufferable: 1'b0, cacheable: 1'b0};
  // Leftmost entry lands on index 2, so index 0 is RAM
  localparam lsu_mpu_pkg::pma_cfg_t PMA_TABLE [2:0] = '{DM_CFG, IO_CFG, RAM_CFG};

  // Addresses for the random phase, one per interesting region
  localparam lsu_mpu_pkg::addr_t ADDR_POOL [8] = '{
    32'h0000_0040, 32'h0000_7FF0, 32'h0000_8010, 32'h0000_FFFC,
    32'h0002_0000, 32'h1000_0008, 32'h2000_0000, 32'hF000_0100
  };

  // Reference verdict for one request
  typedef struct packed {
    logic                     allowed;
    logic [1:0]               memtype;
    lsu_mpu_pkg::mpu_status_e status;
  } verdict_t;

  // Expected core response, in acceptance order
  typedef struct packed {
    lsu_mpu_pkg::mpu_status_e status;
    lsu_mpu_pkg::data_t       rdata;
    int                       acc_cyc;
    logic                     first;
  } exp_t;

  // Pending bus response and the cycle it is driven
  typedef struct packed {
    int                 due;
    lsu_mpu_pkg::data_t rdata;
  } bus_slot_t;

  logic                    clk;
  logic                    rst_n;
  logic                    misaligned_i;
  logic                    core_trans_valid_i;
  lsu_mpu_pkg::data_req_t  core_trans_i;
  logic                    core_trans_ready_o;
  logic                    core_resp_valid_o;
  lsu_mpu_pkg::core_resp_t core_resp_o;
  logic                    bus_trans_valid_o;
  lsu_mpu_pkg::data_req_t  bus_trans_o;
  logic                    bus_trans_ready_i;
  logic                    bus_resp_valid_i;
  lsu_mpu_pkg::bus_resp_t  bus_resp_i;
  lsu_mpu_pkg::pmp_csr_t   csr_pmp_i;
  logic                    mpu_err_o;

  int        seed;
  int        errors;
  int        resp_count;
  int        cyc;
  int        last_due;
  int        last_resp_cyc;
  // Faults answered only after earlier traffic drained
  int        waited_faults;
  // Set once a wait runs out, later waits are skipped
  logic      timed_out;
  exp_t      exp_q [$];
  bus_slot_t bus_q [$];

  lsu_mpu_top #(
    .PMA_NUM_REGIONS (3),
    .PMA_CFG         (PMA_TABLE),
    .PMP_NUM_REGIONS (4),
    .DM_REGION_START (DM_START),
    .DM_REGION_END   (DM_END)
  ) dut (
    .clk                (clk),
    .rst_n              (rst_n),
    .misaligned_i       (misaligned_i),
    .core_trans_valid_i (core_trans_valid_i),
    .core_trans_i       (core_trans_i),
    .core_trans_ready_o (core_trans_ready_o),
    .core_resp_valid_o  (core_resp_valid_o),
    .core_resp_o        (core_resp_o),
    .bus_trans_valid_o  (bus_trans_valid_o),
    .bus_trans_o        (bus_trans_o),
    .bus_trans_ready_i  (bus_trans_ready_i),
    .bus_resp_valid_i   (bus_resp_valid_i),
    .bus_resp_i         (bus_resp_i),
    .csr_pmp_i          (csr_pmp_i),
    .mpu_err_o          (mpu_err_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic verdict_t predict_access(lsu_mpu_pkg::data_req_t req, logic mis,
                                              lsu_mpu_pkg::pmp_csr_t csr);
    verdict_t              v;
    lsu_mpu_pkg::pma_cfg_t pma;
    lsu_mpu_pkg::addr_t    lo;
    logic                  dbg_hit;
    logic                  hit;
    logic                  grant;
    logic                  locked;
    logic                  pma_fail;
    logic                  pmp_fail;
    dbg_hit = req.dbg && (req.addr >= DM_START) && (req.addr <= DM_END);
    // Attributes from the first PMA region holding the address
    pma = lsu_mpu_pkg::PMA_R_DEFAULT;
    hit = 1'b0;
    for (int k = 0; k < 3; k++) begin
      if (!hit && (req.addr >= PMA_TABLE[k].base) && (req.addr <= PMA_TABLE[k].last)) begin
        pma = PMA_TABLE[k];
        hit = 1'b1;
      end
    end
    pma_fail = !dbg_hit && mis && !pma.main;
    // TOR regions, lowest enabled match decides
    hit    = 1'b0;
    grant  = 1'b0;
    locked = 1'b0;
    lo     = '0;
    for (int k = 0; k < lsu_mpu_pkg::PMP_MAX_REGIONS; k++) begin
      if (!hit && csr[k].en && (req.addr >= lo) && (req.addr < csr[k].top)) begin
        hit    = 1'b1;
        grant  = req.we ? csr[k].w : csr[k].r;
        locked = csr[k].lock;
      end
      lo = csr[k].top;
    end
    if (dbg_hit) begin
      pmp_fail = 1'b0;
    end else if (req.priv == lsu_mpu_pkg::PRIV_M) begin
      pmp_fail = hit && locked && !grant;
    end else begin
      pmp_fail = !grant;
    end
    v.allowed = !pma_fail && !pmp_fail;
    v.memtype = dbg_hit ? 2'b00 : {pma.cacheable, pma.bufferable};
    if (v.allowed) begin
      v.status = lsu_mpu_pkg::MPU_OK;
    end else begin
      v.status = req.we ? lsu_mpu_pkg::MPU_WR_FAULT : lsu_mpu_pkg::MPU_RE_FAULT;
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Bus responder, in order, 1 to 3 cycles after accept
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    bus_slot_t slot;
    int        delay;
    if (!rst_n) begin
      bus_trans_ready_i <= 1'b0;
      bus_resp_valid_i  <= 1'b0;
    end else begin
      bus_trans_ready_i <= (($random(seed) & 3) != 0);
      if (bus_trans_valid_o && bus_trans_ready_i) begin
        delay    = 1 + (($random(seed) & 32'h7FFF_FFFF) % 3);
        slot.due = cyc + delay - 1;
        // Never overtake an earlier response
        if (slot.due <= last_due) begin
          slot.due = last_due + 1;
        end
        last_due   = slot.due;
        slot.rdata = ~bus_trans_o.addr;
        bus_q.push_back(slot);
      end
      if ((bus_q.size() != 0) && (bus_q[0].due <= cyc)) begin
        bus_resp_valid_i <= 1'b1;
        bus_resp_i       <= '{rdata: bus_q[0].rdata, err: 1'b0};
        void'(bus_q.pop_front());
      end else begin
        bus_resp_valid_i <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    verdict_t               v;
    exp_t                   e;
    int                     want_cyc;
    lsu_mpu_pkg::data_req_t fwd;
    if (rst_n) begin
      // Responses first, so the queue holds only earlier traffic below
      if (core_resp_valid_o) begin
        if (exp_q.size() == 0) begin
          $display("Core response at %0t with no request outstanding", $time);
          errors++;
        end else begin
          e = exp_q.pop_front();
          resp_count++;
          if (core_resp_o.mpu_status != e.status) begin
            $display("ERROR %0t core_resp_o.mpu_status exp %0d got %0d",
                     $time, e.status, core_resp_o.mpu_status);
            errors++;
          end
          if (core_resp_o.bus_resp.rdata != e.rdata) begin
            $display("ERROR %0t core_resp_o.bus_resp.rdata exp %h got %h",
                     $time, e.rdata, core_resp_o.bus_resp.rdata);
            errors++;
          end
          if (core_resp_o.bus_resp.err != 1'b0) begin
            $display("ERROR %0t core_resp_o.bus_resp.err exp 0 got 1", $time);
            errors++;
          end
          // Fault reply one cycle after accept or after the last earlier response
          if (e.status != lsu_mpu_pkg::MPU_OK) begin
            want_cyc = e.first ? e.acc_cyc + 1 : last_resp_cyc + 1;
            if (!e.first) begin
              waited_faults++;
            end
            if (cyc != want_cyc) begin
              $display("ERROR %0t fault response cycle exp %0d got %0d",
                       $time, want_cyc, cyc);
              errors++;
            end
          end
        end
        last_resp_cyc = cyc;
      end
      if (core_trans_valid_i) begin
        v = predict_access(core_trans_i, misaligned_i, csr_pmp_i);
        if (mpu_err_o != !v.allowed) begin
          $display("ERROR %0t mpu_err_o exp %b got %b", $time, !v.allowed, mpu_err_o);
          errors++;
        end
        if (bus_trans_valid_o && !v.allowed) begin
          $display("Faulting request to %h reached the bus at %0t", core_trans_i.addr, $time);
          errors++;
        end
        if (bus_trans_valid_o && bus_trans_ready_i) begin
          if (bus_trans_o.memtype != v.memtype) begin
            $display("ERROR %0t bus_trans_o.memtype exp %b got %b",
                     $time, v.memtype, bus_trans_o.memtype);
            errors++;
          end
          // All other request fields pass through unchanged
          fwd         = core_trans_i;
          fwd.memtype = v.memtype;
          if (bus_trans_o != fwd) begin
            $display("ERROR %0t bus_trans_o exp %h got %h", $time, fwd, bus_trans_o);
            errors++;
          end
        end
        if (core_trans_ready_o) begin
          if (v.allowed && !(bus_trans_valid_o && bus_trans_ready_i)) begin
            $display("Request to %h accepted without a bus accept at %0t",
                     core_trans_i.addr, $time);
            errors++;
          end
          e.status  = v.status;
          e.rdata   = v.allowed ? ~core_trans_i.addr : '0;
          e.acc_cyc = cyc;
          e.first   = (exp_q.size() == 0);
          exp_q.push_back(e);
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic end_run();
    $display("Responses checked: %0d, errors: %0d", resp_count, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  // Present one request and hold it until accepted, valid stays high
  task automatic send_req(input lsu_mpu_pkg::addr_t addr, input logic we,
                          input lsu_mpu_pkg::privlvl_e priv, input logic dbg,
                          input logic mis);
    lsu_mpu_pkg::data_req_t req;
    int                     n;
    if (timed_out) begin
      return;
    end
    req         = '0;
    req.addr    = addr;
    req.we      = we;
    req.be      = 4'hF;
    req.wdata   = $random(seed);
    req.priv    = priv;
    req.dbg     = dbg;
    // Junk memtype, the DUT overwrites it
    req.memtype = 2'b11;
    core_trans_valid_i <= 1'b1;
    core_trans_i       <= req;
    misaligned_i       <= mis;
    n = 0;
    @(posedge clk);
    while (!core_trans_ready_o && (n < TIMEOUT_CYCLES)) begin
      n++;
      @(posedge clk);
    end
    if (!core_trans_ready_o) begin
      $display("Timeout, request to %h was never accepted", addr);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  // Drop valid and wait for every expected response
  task automatic drain_traffic();
    int n;
    if (timed_out) begin
      return;
    end
    core_trans_valid_i <= 1'b0;
    misaligned_i       <= 1'b0;
    n = 0;
    @(posedge clk);
    while ((exp_q.size() != 0) && (n < TIMEOUT_CYCLES)) begin
      n++;
      @(posedge clk);
    end
    if (exp_q.size() != 0) begin
      $display("Timeout, %0d core responses never arrived", exp_q.size());
      errors++;
      timed_out = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int                    pick;
    lsu_mpu_pkg::privlvl_e rnd_priv;
    logic                  rnd_we;
    logic                  rnd_dbg;
    logic                  rnd_mis;
    seed               = 99;
    errors             = 0;
    resp_count         = 0;
    cyc                = 0;
    last_due           = 0;
    last_resp_cyc      = 0;
    waited_faults      = 0;
    timed_out          = 1'b0;
    clk                = 1'b0;
    rst_n              = 1'b0;
    misaligned_i       = 1'b0;
    core_trans_valid_i = 1'b0;
    core_trans_i       = '0;
    bus_trans_ready_i  = 1'b0;
    bus_resp_valid_i   = 1'b0;
    bus_resp_i         = '0;
    // RAM low half RW, high half RO, locked no-access hole, I/O RW
    csr_pmp_i    = '0;
    csr_pmp_i[0] = '{top: 32'h0000_8000, r: 1'b1, w: 1'b1, en: 1'b1, lock: 1'b0};
    csr_pmp_i[1] = '{top: 32'h0001_0000, r: 1'b1, w: 1'b0, en: 1'b1, lock: 1'b0};
    csr_pmp_i[2] = '{top: 32'h1000_0000, r: 1'b0, w: 1'b0, en: 1'b1, lock: 1'b1};
    csr_pmp_i[3] = '{top: 32'h1000_1000, r: 1'b1, w: 1'b1, en: 1'b1, lock: 1'b0};

    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (core_resp_valid_o || bus_trans_valid_o) begin
      $display("Response or bus valid high right after reset");
      errors++;
    end

    // Plain RAM traffic
    send_req(32'h0000_0100, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0000_0200, 1'b1, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0000_8100, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    drain_traffic();
    // User faults with nothing outstanding
    send_req(32'h0000_8104, 1'b1, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0002_0000, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    drain_traffic();
    // Fault queued behind in-flight reads
    send_req(32'h0000_0010, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0000_0014, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0000_0018, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'h0000_8200, 1'b1, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    drain_traffic();
    // Machine mode, unlocked allows and locked denies
    send_req(32'h0000_8300, 1'b1, lsu_mpu_pkg::PRIV_M, 1'b0, 1'b0);
    send_req(32'h0002_0000, 1'b0, lsu_mpu_pkg::PRIV_M, 1'b0, 1'b0);
    send_req(32'h0002_0004, 1'b1, lsu_mpu_pkg::PRIV_M, 1'b0, 1'b0);
    drain_traffic();
    // Misaligned to I/O faults, to RAM passes
    send_req(32'h1000_0004, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b1);
    send_req(32'h0000_0102, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b1);
    send_req(32'h1000_0008, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    drain_traffic();
    // Debug module range, no PMP region covers it
    send_req(32'hF000_0010, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b1, 1'b0);
    send_req(32'hF000_0010, 1'b0, lsu_mpu_pkg::PRIV_U, 1'b0, 1'b0);
    send_req(32'hF000_0020, 1'b1, lsu_mpu_pkg::PRIV_U, 1'b1, 1'b1);
    drain_traffic();

    // Random mix with gaps
    for (int i = 0; i < 40; i++) begin
      pick     = ($random(seed) & 32'h7FFF_FFFF) % 8;
      rnd_we   = (($random(seed) & 1) != 0);
      rnd_priv = (($random(seed) & 1) != 0) ? lsu_mpu_pkg::PRIV_M : lsu_mpu_pkg::PRIV_U;
      rnd_dbg  = (ADDR_POOL[pick] >= DM_START) && (($random(seed) & 1) != 0);
      rnd_mis  = (($random(seed) & 7) == 0);
      send_req(ADDR_POOL[pick], rnd_we, rnd_priv, rnd_dbg, rnd_mis);
      if (($random(seed) & 3) == 0) begin
        core_trans_valid_i <= 1'b0;
        @(posedge clk);
      end
    end
    drain_traffic();

    if (!timed_out && (resp_count < 50)) begin
      $display("Only %0d responses were checked", resp_count);
      errors++;
    end
    if (!timed_out && (waited_faults == 0)) begin
      $display("No fault response ever waited behind earlier bus traffic");
      errors++;
    end
    end_run();
  end

endmodule

`default_nettype wire
